//--- logic/midi_params.svh
`ifndef MIDI_PARAMS_SVH
`define MIDI_PARAMS_SVH

//////////////////////////////////////////////////
// Serial bit timing
//////////////////////////////////////////////////

// Clock cycles per MIDI bit
// Set to clk / 31250 for a real build
`define MIDI_CLKS_PER_BIT 16

//////////////////////////////////////////////////
// Channel status codes, upper nibble
//////////////////////////////////////////////////

`define MIDI_ST_CTRL  4'hB
`define MIDI_ST_PRG   4'hC
`define MIDI_ST_CH_AT 4'hD

`endif

//--- logic/midi_pkg.sv
package midi_pkg;

    //////////////////////////////////////////////////
    // Byte and message types
    //////////////////////////////////////////////////

    // One byte off the MIDI line
    typedef logic [7:0] midi_byte_t;

    // Kind of the current running status
    typedef enum logic [2:0] {
        MSG_NONE,
        MSG_NOTE_OFF,
        MSG_NOTE_ON,
        MSG_POLY_AT,
        MSG_CTRL,
        MSG_PRG,
        MSG_CH_AT,
        MSG_PITCH
    } msg_kind_e;

    // Serial receiver states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

//--- logic/midi_uart_rx.sv
`timescale 1ns/10ps

`include "midi_params.svh"

module midi_uart_rx (
    input  logic                 clk,
    input  logic                 reset_reg_N,
    input  logic                 midi_in,
    output midi_pkg::midi_byte_t rx_byte,
    output logic                 rx_valid,
    output logic                 rx_frame_err
);

    // Counter wide enough for one full bit
    localparam int CNT_W = $clog2(`MIDI_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`MIDI_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`MIDI_CLKS_PER_BIT / 2 - 1);

    midi_pkg::rx_state_e state;
    logic                midi_meta;
    logic                midi_sync;
    logic [CNT_W-1:0]    clk_cnt;
    logic [2:0]          bit_idx;
    logic                wait_high;

    //////////////////////////////////////////////////
    // Input synchronizer
    //////////////////////////////////////////////////

    // Line idles high
    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            midi_meta <= 1'b1;
            midi_sync <= 1'b1;
        end else begin
            midi_meta <= midi_in;
            midi_sync <= midi_meta;
        end
    end

    //////////////////////////////////////////////////
    // Receive FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            state        <= midi_pkg::RX_IDLE;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            wait_high    <= 1'b0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            // Strobes last one cycle
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
            case (state)
                midi_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    // After a framing error wait for the line to go high first
                    if (midi_sync) begin
                        wait_high <= 1'b0;
                    end else if (!wait_high) begin
                        state <= midi_pkg::RX_START;
                    end
                end
                midi_pkg::RX_START: begin
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        // Recheck start bit at its center
                        state   <= midi_sync ? midi_pkg::RX_IDLE : midi_pkg::RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                midi_pkg::RX_DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        // Eighth data bit taken
                        if (bit_idx == 3'd7) begin
                            state <= midi_pkg::RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                midi_pkg::RX_STOP: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        state   <= midi_pkg::RX_IDLE;
                        if (midi_sync) begin
                            rx_valid <= 1'b1;
                        end else begin
                            // Low stop bit drops the byte
                            rx_frame_err <= 1'b1;
                            wait_high    <= 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= midi_pkg::RX_IDLE;
            endcase
        end
    end

    // Data shift register, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == midi_pkg::RX_DATA && clk_cnt == BIT_LAST) begin
            rx_byte <= {midi_sync, rx_byte[7:1]};
        end
    end

    // good byte and framing error are exclusive
    assert property (@(posedge clk) disable iff (!reset_reg_N)
        !(rx_valid && rx_frame_err));

endmodule

//--- logic/midi_byte_seq.sv
`timescale 1ns/10ps

`include "midi_params.svh"

module midi_byte_seq (
    input  logic                 clk,
    input  logic                 reset_reg_N,
    input  midi_pkg::midi_byte_t rx_byte,
    input  logic                 rx_valid,
    output logic                 seq_trigger,
    output midi_pkg::midi_byte_t seq_databyte,
    output logic                 is_data_byte,
    output logic                 is_velocity,
    output logic                 is_st_ctrl,
    output logic                 is_st_prg_change
);

    midi_pkg::msg_kind_e run_kind;
    logic                second_q;
    logic                take_data;

    //////////////////////////////////////////////////
    // Status decoding
    //////////////////////////////////////////////////

    // Upper nibble to message kind
    function automatic midi_pkg::msg_kind_e kind_of(input logic [3:0] nib);
        midi_pkg::msg_kind_e k;
        case (nib)
            4'h8:           k = midi_pkg::MSG_NOTE_OFF;
            4'h9:           k = midi_pkg::MSG_NOTE_ON;
            4'hA:           k = midi_pkg::MSG_POLY_AT;
            `MIDI_ST_CTRL:  k = midi_pkg::MSG_CTRL;
            `MIDI_ST_PRG:   k = midi_pkg::MSG_PRG;
            `MIDI_ST_CH_AT: k = midi_pkg::MSG_CH_AT;
            4'hE:           k = midi_pkg::MSG_PITCH;
            default:        k = midi_pkg::MSG_NONE;
        endcase
        return k;
    endfunction

    // Kinds with a single data byte
    function automatic logic one_byte(input midi_pkg::msg_kind_e k);
        return (k == midi_pkg::MSG_PRG) || (k == midi_pkg::MSG_CH_AT);
    endfunction

    // Data byte under a known status
    assign take_data = rx_valid && !rx_byte[7] && (run_kind != midi_pkg::MSG_NONE);

    //////////////////////////////////////////////////
    // Running status and classification
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            run_kind         <= midi_pkg::MSG_NONE;
            second_q         <= 1'b0;
            seq_trigger      <= 1'b0;
            is_data_byte     <= 1'b0;
            is_velocity      <= 1'b0;
            is_st_ctrl       <= 1'b0;
            is_st_prg_change <= 1'b0;
        end else begin
            seq_trigger      <= take_data;
            // Status levels follow running status
            is_st_ctrl       <= (run_kind == midi_pkg::MSG_CTRL);
            is_st_prg_change <= (run_kind == midi_pkg::MSG_PRG);
            if (take_data) begin
                is_data_byte <= !second_q;
                is_velocity  <= second_q;
                // Count wraps for running status
                second_q     <= one_byte(run_kind) ? 1'b0 : !second_q;
            end else if (rx_valid && rx_byte[7]) begin
                if (rx_byte[7:4] != 4'hF) begin
                    // Channel status
                    run_kind <= kind_of(rx_byte[7:4]);
                    second_q <= 1'b0;
                end else if (!rx_byte[3]) begin
                    // System common clears status
                    run_kind <= midi_pkg::MSG_NONE;
                    second_q <= 1'b0;
                end
                // F8 to FF real time leaves status alone
            end
        end
    end

    // Data byte payload
    always_ff @(posedge clk) begin
        if (take_data) begin
            seq_databyte <= rx_byte;
        end
    end

    // First and second data byte never flagged at once
    assert property (@(posedge clk) disable iff (!reset_reg_N)
        seq_trigger |-> !(is_data_byte && is_velocity));

endmodule

//--- logic/ctrl_cmd_decode.sv
`timescale 1ns/10ps

module ctrl_cmd_decode (
    input  logic                 clk,
    input  logic                 reset_reg_N,
    input  logic                 seq_trigger,
    input  logic                 is_st_ctrl,
    input  logic                 is_st_prg_change,
    input  logic                 is_data_byte,
    input  logic                 is_velocity,
    input  midi_pkg::midi_byte_t seq_databyte,
    output logic                 ctrl_cmd,
    output logic                 prg_ch_cmd,
    output midi_pkg::midi_byte_t octrl,
    output midi_pkg::midi_byte_t octrl_data,
    output midi_pkg::midi_byte_t prg_ch_data
);

    logic ctrl_num_hit;
    logic ctrl_val_hit;
    logic prg_hit;

    // Byte roles for this trigger
    assign ctrl_num_hit = seq_trigger && is_st_ctrl && is_data_byte;
    assign ctrl_val_hit = seq_trigger && is_st_ctrl && is_velocity;
    assign prg_hit      = seq_trigger && is_st_prg_change && is_data_byte;

    //////////////////////////////////////////////////
    // Command pulses
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            ctrl_cmd   <= 1'b0;
            prg_ch_cmd <= 1'b0;
        end else begin
            // Control fires on the value byte
            ctrl_cmd   <= ctrl_val_hit;
            prg_ch_cmd <= prg_hit;
        end
    end

    // Held data stays until overwritten
    always_ff @(posedge clk) begin
        if (ctrl_num_hit) begin
            octrl <= seq_databyte;
        end
        if (ctrl_val_hit) begin
            octrl_data <= seq_databyte;
        end
        if (prg_hit) begin
            prg_ch_data <= seq_databyte;
        end
    end

    // One command kind per cycle
    assert property (@(posedge clk) disable iff (!reset_reg_N)
        !(ctrl_cmd && prg_ch_cmd));

endmodule

//--- logic/midi_ctrl_top.sv
`timescale 1ns/10ps

module midi_ctrl_top (
    input  logic                 clk,
    input  logic                 reset_reg_N,
    input  logic                 midi_in,
    output logic                 ctrl_cmd,
    output midi_pkg::midi_byte_t ctrl_num,
    output midi_pkg::midi_byte_t ctrl_value,
    output logic                 prg_cmd,
    output midi_pkg::midi_byte_t prg_num,
    output logic                 rx_frame_err
);

    // Receiver to sequencer
    midi_pkg::midi_byte_t rx_byte;
    logic                 rx_valid;

    // Sequencer to decoder
    logic                 seq_trigger;
    midi_pkg::midi_byte_t seq_databyte;
    logic                 is_data_byte;
    logic                 is_velocity;
    logic                 is_st_ctrl;
    logic                 is_st_prg_change;

    //////////////////////////////////////////////////
    // Serial receiver
    //////////////////////////////////////////////////

    midi_uart_rx u_rx (
        .clk          (clk),
        .reset_reg_N  (reset_reg_N),
        .midi_in      (midi_in),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    // Running status tracking
    midi_byte_seq u_seq (
        .clk              (clk),
        .reset_reg_N      (reset_reg_N),
        .rx_byte          (rx_byte),
        .rx_valid         (rx_valid),
        .seq_trigger      (seq_trigger),
        .seq_databyte     (seq_databyte),
        .is_data_byte     (is_data_byte),
        .is_velocity      (is_velocity),
        .is_st_ctrl       (is_st_ctrl),
        .is_st_prg_change (is_st_prg_change)
    );

    // Control and program change commands
    ctrl_cmd_decode u_dec (
        .clk              (clk),
        .reset_reg_N      (reset_reg_N),
        .seq_trigger      (seq_trigger),
        .is_st_ctrl       (is_st_ctrl),
        .is_st_prg_change (is_st_prg_change),
        .is_data_byte     (is_data_byte),
        .is_velocity      (is_velocity),
        .seq_databyte     (seq_databyte),
        .ctrl_cmd         (ctrl_cmd),
        .prg_ch_cmd       (prg_cmd),
        .octrl            (ctrl_num),
        .octrl_data       (ctrl_value),
        .prg_ch_data      (prg_num)
    );

endmodule

//--- test/midi_ctrl_tb.sv
`timescale 1ns/10ps

`include "midi_params.svh"

module midi_ctrl_tb;

    logic                 clk;
    logic                 reset_reg_N;
    logic                 midi_in;
    logic                 ctrl_cmd;
    midi_pkg::midi_byte_t ctrl_num;
    midi_pkg::midi_byte_t ctrl_value;
    logic                 prg_cmd;
    midi_pkg::midi_byte_t prg_num;
    logic                 rx_frame_err;

    // Byte stream and its bad-stop flags
    midi_pkg::midi_byte_t byte_list[$];
    logic                 bad_list[$];

    // Expected results from the reference model
    midi_pkg::midi_byte_t exp_ctrl_num[$];
    midi_pkg::midi_byte_t exp_ctrl_val[$];
    midi_pkg::midi_byte_t exp_prg[$];
    int                   exp_frame_errs;
    int                   seen_frame_errs;

    int cycle_cnt = 0;
    int cycle_limit;

    midi_ctrl_top uut (
        .clk          (clk),
        .reset_reg_N  (reset_reg_N),
        .midi_in      (midi_in),
        .ctrl_cmd     (ctrl_cmd),
        .ctrl_num     (ctrl_num),
        .ctrl_value   (ctrl_value),
        .prg_cmd      (prg_cmd),
        .prg_num      (prg_num),
        .rx_frame_err (rx_frame_err)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Error exit
    //////////////////////////////////////////////////

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    //////////////////////////////////////////////////
    // Stream building and reference model
    //////////////////////////////////////////////////

    function automatic void queue_byte(input midi_pkg::midi_byte_t b, input logic bad);
        byte_list.push_back(b);
        bad_list.push_back(bad);
    endfunction

    // Running status rules applied to the whole stream
    function automatic void model_stream();
        logic [3:0]           st;
        logic                 have_st;
        logic                 second;
        midi_pkg::midi_byte_t num;
        midi_pkg::midi_byte_t b;
        int                   i;
        st = 4'h0;
        have_st = 1'b0;
        second = 1'b0;
        num = 8'h00;
        exp_frame_errs = 0;
        for (i = 0; i < byte_list.size(); i++) begin
            b = byte_list[i];
            if (bad_list[i]) begin
                // Dropped by the receiver
                exp_frame_errs++;
            end else if (b[7:3] == 5'b11111) begin
                // Real time keeps the status
            end else if (b[7:4] == 4'hF) begin
                have_st = 1'b0;
                second = 1'b0;
            end else if (b[7]) begin
                have_st = 1'b1;
                st = b[7:4];
                second = 1'b0;
            end else if (have_st) begin
                if (st == `MIDI_ST_CTRL) begin
                    if (second) begin
                        exp_ctrl_num.push_back(num);
                        exp_ctrl_val.push_back(b);
                    end else begin
                        num = b;
                    end
                end else if (st == `MIDI_ST_PRG) begin
                    exp_prg.push_back(b);
                end
                // One data byte for program change and channel aftertouch
                if (st == `MIDI_ST_PRG || st == `MIDI_ST_CH_AT) begin
                    second = 1'b0;
                end else begin
                    second = !second;
                end
            end
        end
    endfunction

    //////////////////////////////////////////////////
    // Serial stimulus
    //////////////////////////////////////////////////

    // One bit changed 1 ns after the edge
    task automatic drive_bit(input logic v);
        @(posedge clk);
        #1 midi_in = v;
        repeat (`MIDI_CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic shift_frame(input midi_pkg::midi_byte_t b, input logic stop_bit);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(stop_bit);
    endtask

    task automatic send_byte(input midi_pkg::midi_byte_t b);
        shift_frame(b, 1'b1);
    endtask

    // Low stop bit, then one idle bit so the receiver rearms
    task automatic send_bad_byte(input midi_pkg::midi_byte_t b);
        shift_frame(b, 1'b0);
        drive_bit(1'b1);
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_ctrl(input midi_pkg::midi_byte_t number,
                              input midi_pkg::midi_byte_t value);
        if (number !== exp_ctrl_num[0] || value !== exp_ctrl_val[0]) begin
            fail_run($sformatf("Mismatch at %0t: control got %h/%h, expected %h/%h",
                     $time, number, value, exp_ctrl_num[0], exp_ctrl_val[0]));
        end else begin
            void'(exp_ctrl_num.pop_front());
            void'(exp_ctrl_val.pop_front());
        end
    endtask

    task automatic check_prg(input midi_pkg::midi_byte_t number);
        if (number !== exp_prg[0]) begin
            fail_run($sformatf("Mismatch at %0t: program got %h, expected %h",
                     $time, number, exp_prg[0]));
        end else begin
            void'(exp_prg.pop_front());
        end
    endtask

    task automatic check_frame_errs(input int count);
        if (count != exp_frame_errs) begin
            fail_run($sformatf("Mismatch at %0t: %0d framing errors, expected %0d",
                     $time, count, exp_frame_errs));
        end
    endtask

    //////////////////////////////////////////////////
    // Checker sampled at the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (ctrl_cmd) begin
            if (exp_ctrl_num.size() == 0) begin
                fail_run("Control command pulsed with none expected");
            end else begin
                check_ctrl(ctrl_num, ctrl_value);
            end
        end
        if (prg_cmd) begin
            if (exp_prg.size() == 0) begin
                fail_run("Program command pulsed with none expected");
            end else begin
                check_prg(prg_num);
            end
        end
        if (rx_frame_err) begin
            seen_frame_errs++;
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            fail_run("Timeout, the byte stream did not finish in time");
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int i;
        reset_reg_N = 1'b0;
        midi_in = 1'b1;
        cycle_limit = 0;
        seen_frame_errs = 0;
        void'($urandom(32'h21f0_d5d0));

        // Full control change
        queue_byte(8'hB3, 1'b0);
        queue_byte(8'h07, 1'b0);
        queue_byte(8'h64, 1'b0);
        // Running status pairs
        for (i = 0; i < 40; i++) begin
            queue_byte(8'($urandom() & 32'h7F), 1'b0);
            queue_byte(8'($urandom() & 32'h7F), 1'b0);
        end
        // Program change plus repeats
        queue_byte(8'hC5, 1'b0);
        for (i = 0; i < 4; i++) begin
            queue_byte(8'($urandom() & 32'h7F), 1'b0);
        end
        // Real time inside a pair, then F0 clears status
        queue_byte(8'hB2, 1'b0);
        queue_byte(8'h0A, 1'b0);
        queue_byte(8'hF8, 1'b0);
        queue_byte(8'h33, 1'b0);
        queue_byte(8'hF0, 1'b0);
        queue_byte(8'h11, 1'b0);
        queue_byte(8'h22, 1'b0);
        // Note on and aftertouch, no commands
        queue_byte(8'h90, 1'b0);
        queue_byte(8'h3C, 1'b0);
        queue_byte(8'h7F, 1'b0);
        queue_byte(8'h3E, 1'b0);
        queue_byte(8'h40, 1'b0);
        queue_byte(8'hD0, 1'b0);
        queue_byte(8'h55, 1'b0);
        queue_byte(8'h56, 1'b0);
        queue_byte(8'hB0, 1'b0);
        queue_byte(8'h01, 1'b0);
        queue_byte(8'h02, 1'b0);
        // Framing error drops a byte
        queue_byte(8'hB1, 1'b0);
        queue_byte(8'h45, 1'b1);
        queue_byte(8'h10, 1'b0);
        queue_byte(8'h20, 1'b0);

        model_stream();
        cycle_limit = byte_list.size() * 10 * `MIDI_CLKS_PER_BIT + 200;

        repeat (4) @(posedge clk);
        #1 reset_reg_N = 1'b1;
        repeat (4) @(posedge clk);

        for (i = 0; i < byte_list.size(); i++) begin
            if (bad_list[i]) begin
                send_bad_byte(byte_list[i]);
            end else begin
                send_byte(byte_list[i]);
            end
        end
        // Let the last command drain
        repeat (20) @(posedge clk);

        check_frame_errs(seen_frame_errs);
        if (exp_ctrl_num.size() != 0 || exp_prg.size() != 0) begin
            fail_run("Some expected commands never arrived");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+logic
logic/midi_pkg.sv
logic/midi_uart_rx.sv
logic/midi_byte_seq.sv
logic/ctrl_cmd_decode.sv
logic/midi_ctrl_top.sv
test/midi_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MIDI controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
verilator --binary --timing --assert -j 0 -f src.f \
    --top-module midi_ctrl_tb -o midi_ctrl_sim &&
./obj_dir/midi_ctrl_sim || {
    echo "simulation failed"
    exit 1
}
